// ==== files.f ====
+incdir+verification
src/mipsPkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/registerFile.sv
src/hazardUnit.sv
src/executeStage.sv
src/memWritebackStage.sv
src/pipelineCpu.sv
verification/pipelineCpuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module pipelineCpuTb -Mdir obj_dir
output=$(./obj_dir/VpipelineCpuTb) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "^ALL TESTS PASSED$"; then
  exit 0
fi
exit 1

// ==== verification/isaModel.svh ====
// Sequential reference interpreter, included in the testbench to predict stores and the halt PC
`ifndef isaModelSvh
`define isaModelSvh

// Expected stores in program order
wordT expAddr [$];
wordT expData [$];
// Address of the HALT that ends the run
wordT haltPc;

////////////////////
// Instruction-level model
////////////////////

task automatic runModel();
  wordT regs [32];
  wordT pcM, nextPc, ins, a, b, immS, immZ, val;
  opcodeT op;
  regIdxT dst;
  logic wr, done;
  int steps, i;
  for (i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  pcM = pcInit;
  done = 1'b0;
  steps = 0;
  while (!done && steps < 1000) begin
    ins = progMem[pcM[7:2]];
    op = ins[31:26];
    a = regs[ins[25:21]];
    b = regs[ins[20:16]];
    immS = {{16{ins[15]}}, ins[15:0]};
    immZ = {16'h0000, ins[15:0]};
    nextPc = pcM + 32'd4;
    wr = 1'b0;
    // I-type results land in rt
    dst = ins[20:16];
    val = '0;
    case (op)
      opRtype: begin
        dst = ins[15:11];
        wr = 1'b1;
        case (ins[5:0])
          fnAddu:  val = a + b;
          fnSubu:  val = a - b;
          fnAnd:   val = a & b;
          fnOr:    val = a | b;
          fnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          // Zero word and unknown funct do nothing
          default: wr = 1'b0;
        endcase
      end
      opAddiu: begin
        val = a + immS;
        wr = 1'b1;
      end
      opOri: begin
        val = a | immZ;
        wr = 1'b1;
      end
      opLui: begin
        val = {ins[15:0], 16'h0000};
        wr = 1'b1;
      end
      opBeq: if (a == b) nextPc = nextPc + (immS << 2);
      opBne: if (a != b) nextPc = nextPc + (immS << 2);
      opJ:   nextPc = {nextPc[31:28], ins[25:0], 2'b00};
      opSw: begin
        expAddr.push_back(a + immS);
        expData.push_back(b);
      end
      opHalt: begin
        done = 1'b1;
        haltPc = pcM;
      end
      default: ;
    endcase
    // $0 stays zero
    if (wr && dst != regZero) begin
      regs[dst] = val;
    end
    pcM = nextPc;
    steps++;
  end
endtask

`endif

// ==== verification/pipelineCpuTb.sv ====
// Self-checking testbench for the pipelined core, random program against a reference model
`timescale 1ns/10ps

module pipelineCpuTb;
  import mipsPkg::*;

  localparam wordT pcInit = 32'h0000_0100;
  localparam int timeoutCycles = 2000;
  // Sample point after the falling-edge drive
  localparam int settleNs = 10;
  localparam functT functList [5] = '{fnAddu, fnSubu, fnAnd, fnOr, fnSlt};

  logic CLK, nRST, ihit, imemREN, dmemWEN, halt;
  wordT imemload, imemaddr, dmemaddr, dmemstore;

  // Instruction memory with HALT padding past the program
  wordT progMem [64];
  int stallLeft;
  int storeCount;
  wordT lastAddr;
  logic lastIhit;

  `include "isaModel.svh"

  pipelineCpu #(.pcInit(pcInit)) pipelineCpu_i (.CLK, .nRST, .imemload, .ihit, .imemaddr,
    .imemREN, .dmemWEN, .dmemaddr, .dmemstore, .halt);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////
  // Failure reporting and compares
  ////////////////////

  task automatic stopWithFailure(string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkWord(string testName, wordT expected, wordT actual);
    if (expected !== actual) begin
      stopWithFailure($sformatf("ERROR %s expected %h actual %h", testName, expected, actual));
    end
  endtask

  task automatic checkCount(string testName, int expected, int actual);
    if (expected != actual) begin
      stopWithFailure($sformatf("ERROR %s expected %0d actual %0d", testName, expected, actual));
    end
  endtask

  ////////////////////
  // Program generation
  ////////////////////

  function automatic wordT encodeR(functT fn, regIdxT rd, regIdxT rs, regIdxT rt);
    return {opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic wordT encodeI(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic regIdxT randomReg(int unsigned lowest);
    return regIdxT'(lowest + $urandom % (8 - lowest));
  endfunction

  task automatic buildProgram();
    int unsigned kind, offset;
    regIdxT rs, rt, rd;
    int i;
    for (i = 0; i < 64; i++) begin
      progMem[i] = {opHalt, 26'd0};
    end
    // Slot 47 keeps the final HALT
    for (i = 0; i < 47; i++) begin
      kind = $urandom % 10;
      rs = randomReg(0);
      rt = randomReg(0);
      rd = randomReg(1);
      offset = $urandom % 4;
      case (kind)
        4: progMem[i] = encodeI(opAddiu, rs, rd, 16'($urandom));
        5: progMem[i] = encodeI(opOri, rs, rd, 16'($urandom));
        6: progMem[i] = encodeI(opLui, regZero, rd, 16'($urandom));
        // Small word-aligned address off $0
        7: progMem[i] = encodeI(opSw, regZero, rt, 16'(4 * ($urandom % 16)));
        8: progMem[i] = encodeI(($urandom % 2 == 0) ? opBeq : opBne, rs, rt, 16'(offset));
        // Word index of a forward target
        9: progMem[i] = {opJ, 26'(pcInit[27:2] + i + 1 + offset)};
        default: progMem[i] = encodeR(functList[$urandom % 5], rd, rs, rt);
      endcase
    end
  endtask

  ////////////////////
  // Per-cycle drive and checks
  ////////////////////

  // ihit about 70% high, with occasional low stretches
  task automatic driveInputs();
    if (stallLeft > 0) begin
      ihit = 1'b0;
      stallLeft--;
    end else if ($urandom % 20 < 17) begin
      ihit = 1'b1;
    end else begin
      ihit = 1'b0;
      stallLeft = int'($urandom % 4);
    end
    imemload = progMem[imemaddr[7:2]];
  endtask

  task automatic checkCycle();
    // No edge advanced the PC with ihit low
    if (!lastIhit) begin
      checkWord("pcHold", lastAddr, imemaddr);
    end
    if (!halt && !imemREN) begin
      stopWithFailure("imemREN low while the core is running");
    end
    if (dmemWEN) begin
      if (!ihit) begin
        stopWithFailure("store strobe raised while ihit is low");
      end
      if (storeCount >= expAddr.size()) begin
        stopWithFailure("store pulse beyond the expected store list");
      end
      checkWord("storeAddr", expAddr[storeCount], dmemaddr);
      checkWord("storeData", expData[storeCount], dmemstore);
      storeCount++;
    end else begin
      checkWord("idleAddr", '0, dmemaddr);
      checkWord("idleData", '0, dmemstore);
    end
    lastAddr = imemaddr;
    lastIhit = ihit;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int cycles;
    void'($urandom(32'h9a9a_a76a));
    nRST = 1'b0;
    ihit = 1'b0;
    imemload = '0;
    stallLeft = 0;
    storeCount = 0;
    buildProgram();
    runModel();
    repeat (5) @(negedge CLK);
    nRST = 1'b1;
    #settleNs;
    // Reset state, before any edge with ihit high
    checkWord("resetPc", pcInit, imemaddr);
    if (dmemWEN || halt || !imemREN) begin
      stopWithFailure("store strobe, halt or imemREN wrong after reset");
    end
    lastAddr = imemaddr;
    lastIhit = 1'b0;
    cycles = 0;
    while (!halt && cycles < timeoutCycles) begin
      @(negedge CLK);
      driveInputs();
      #settleNs;
      checkCycle();
      cycles++;
    end
    if (!halt) begin
      stopWithFailure("halt did not rise within the timeout");
    end
    if (imemREN) begin
      stopWithFailure("imemREN still high after halt");
    end
    // Four fetches past HALT before the freeze
    checkWord("haltPc", haltPc + 32'd16, imemaddr);
    repeat (20) begin
      @(negedge CLK);
      driveInputs();
      #settleNs;
      if (!halt || imemREN) begin
        stopWithFailure("halt dropped or imemREN rose after halt");
      end
      if (dmemWEN) begin
        stopWithFailure("store pulse after halt");
      end
      checkWord("haltHold", haltPc + 32'd16, imemaddr);
    end
    checkCount("storeCount", expAddr.size(), storeCount);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== src/pipelineCpu.sv ====
// Top of the five-stage MIPS core, wiring stages, register file and hazard unit to the memories
`timescale 1ns/10ps

module pipelineCpu #(
  parameter mipsPkg::wordT pcInit = '0
) (
  input  logic          CLK,
  input  logic          nRST,
  input  mipsPkg::wordT imemload,
  input  logic          ihit,
  output mipsPkg::wordT imemaddr,
  output logic          imemREN,
  output logic          dmemWEN,
  output mipsPkg::wordT dmemaddr,
  output mipsPkg::wordT dmemstore,
  output logic          halt
);
  import mipsPkg::*;

  logic advance, squash, takeRedirect;
  pcSelT pcSel;
  wordT branchTarget, jumpTarget, fdInstr, fdPcInc, rdatA, rdatB;
  regIdxT rselA, rselB;
  // Decode/execute register
  wordT deBusA, deBusB, deImm, dePcInc;
  regIdxT deRs, deRt, deDest;
  aluOpT deAluOp;
  logic deUseImm, deWrite, deStore, deIsLui, deIsBeq, deIsBne, deIsJump, deIsHalt;
  logic [25:0] deJumpField;
  // Later stages
  fwdSelT fwdA, fwdB;
  wordT emResult, emStoreData, wbValue;
  regIdxT emDest, mwDest;
  logic emWrite, emStore, emIsHalt, mwWrite;

  // Missing instruction or halt freezes every stage
  assign advance = ihit && !halt;
  assign imemREN = !halt;

  ////////////////////
  // Stages
  ////////////////////

  fetchStage #(.pcInit(pcInit)) fetchStage_i (.CLK, .nRST, .advance, .pcSel, .branchTarget,
    .jumpTarget, .squash, .imemload, .pc(imemaddr), .fdInstr, .fdPcInc);

  decodeStage decodeStage_i (.CLK, .nRST, .advance, .squash, .fdInstr, .fdPcInc, .rdatA, .rdatB,
    .rselA, .rselB, .deBusA, .deBusB, .deImm, .dePcInc, .deRs, .deRt, .deDest, .deAluOp,
    .deUseImm, .deWrite, .deStore, .deIsLui, .deIsBeq, .deIsBne, .deIsJump, .deIsHalt,
    .deJumpField);

  // Written from writeback, read in decode
  registerFile registerFile_i (.CLK, .nRST, .wen(mwWrite), .wsel(mwDest), .wdat(wbValue),
    .rselA, .rselB, .rdatA, .rdatB);

  executeStage executeStage_i (.CLK, .nRST, .advance, .deBusA, .deBusB, .deImm, .dePcInc,
    .deDest, .deAluOp, .deUseImm, .deWrite, .deStore, .deIsLui, .deIsBeq, .deIsBne, .deIsJump,
    .deIsHalt, .deJumpField, .fwdA, .fwdB, .wbValue, .takeRedirect, .pcSel, .branchTarget,
    .jumpTarget, .emResult, .emStoreData, .emDest, .emWrite, .emStore, .emIsHalt);

  hazardUnit hazardUnit_i (.deRs, .deRt, .emDest, .emWrite, .mwDest, .mwWrite, .takeRedirect,
    .fwdA, .fwdB, .squash);

  memWritebackStage memWritebackStage_i (.CLK, .nRST, .advance, .emResult, .emStoreData,
    .emDest, .emWrite, .emStore, .emIsHalt, .dmemWEN, .dmemaddr, .dmemstore, .mwDest,
    .mwWrite, .wbValue, .halt);

endmodule

// ==== src/memWritebackStage.sv ====
// Memory and writeback stage driving the store port, writeback value and sticky halt
`timescale 1ns/10ps

module memWritebackStage (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            advance,
  input  mipsPkg::wordT   emResult,
  input  mipsPkg::wordT   emStoreData,
  input  mipsPkg::regIdxT emDest,
  input  logic            emWrite,
  input  logic            emStore,
  input  logic            emIsHalt,
  output logic            dmemWEN,
  output mipsPkg::wordT   dmemaddr,
  output mipsPkg::wordT   dmemstore,
  output mipsPkg::regIdxT mwDest,
  output logic            mwWrite,
  output mipsPkg::wordT   wbValue,
  output logic            halt
);

  ////////////////////
  // Store port
  ////////////////////

  // One strobe per store, only on an advancing cycle
  assign dmemWEN = emStore && advance;
  // Address and data read as zero with no store
  assign dmemaddr = dmemWEN ? emResult : '0;
  assign dmemstore = dmemWEN ? emStoreData : '0;

  ////////////////////
  // Memory/writeback register
  ////////////////////

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mwWrite <= 1'b0;
    end else if (advance) begin
      mwWrite <= emWrite;
    end
  end

  // Writeback value feeds the register file and forwarding
  always_ff @(posedge CLK) begin
    if (advance) begin
      wbValue <= emResult;
      mwDest <= emDest;
    end
  end

  // Halt rises as HALT enters this register
  // and holds until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (advance && emIsHalt) begin
      halt <= 1'b1;
    end
  end

endmodule

// ==== src/executeStage.sv ====
// Execute stage with forwarding muxes, ALU, redirect logic and execute/memory register
`timescale 1ns/10ps

module executeStage (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            advance,
  input  mipsPkg::wordT   deBusA,
  input  mipsPkg::wordT   deBusB,
  input  mipsPkg::wordT   deImm,
  input  mipsPkg::wordT   dePcInc,
  input  mipsPkg::regIdxT deDest,
  input  mipsPkg::aluOpT  deAluOp,
  input  logic            deUseImm,
  input  logic            deWrite,
  input  logic            deStore,
  input  logic            deIsLui,
  input  logic            deIsBeq,
  input  logic            deIsBne,
  input  logic            deIsJump,
  input  logic            deIsHalt,
  input  logic [25:0]     deJumpField,
  input  mipsPkg::fwdSelT fwdA,
  input  mipsPkg::fwdSelT fwdB,
  input  mipsPkg::wordT   wbValue,
  output logic            takeRedirect,
  output mipsPkg::pcSelT  pcSel,
  output mipsPkg::wordT   branchTarget,
  output mipsPkg::wordT   jumpTarget,
  output mipsPkg::wordT   emResult,
  output mipsPkg::wordT   emStoreData,
  output mipsPkg::regIdxT emDest,
  output logic            emWrite,
  output logic            emStore,
  output logic            emIsHalt
);
  import mipsPkg::*;

  wordT opA, opB, aluB, aluOut, result;
  logic zero, takeBranch;

  ////////////////////
  // Operands
  ////////////////////

  always_comb begin
    case (fwdA)
      fwdMem:  opA = emResult;
      fwdWb:   opA = wbValue;
      default: opA = deBusA;
    endcase
    case (fwdB)
      fwdMem:  opB = emResult;
      fwdWb:   opB = wbValue;
      default: opB = deBusB;
    endcase
  end

  // Forwarded rt is also the store data
  assign aluB = deUseImm ? deImm : opB;

  // ALU
  always_comb begin
    case (deAluOp)
      aluSub:  aluOut = opA - aluB;
      aluAnd:  aluOut = opA & aluB;
      aluOr:   aluOut = opA | aluB;
      aluSlt:  aluOut = {31'd0, $signed(opA) < $signed(aluB)};
      default: aluOut = opA + aluB;
    endcase
  end

  assign zero = (aluOut == '0);
  // LUI places the immediate in the upper half
  assign result = deIsLui ? {deImm[15:0], 16'h0000} : aluOut;

  ////////////////////
  // Redirect
  ////////////////////

  assign branchTarget = dePcInc + {deImm[29:0], 2'b00};
  assign jumpTarget = {dePcInc[31:28], deJumpField, 2'b00};
  assign takeBranch = (deIsBeq && zero) || (deIsBne && !zero);
  assign takeRedirect = takeBranch || deIsJump;

  always_comb begin
    if (deIsJump) begin
      pcSel = pcJump;
    end else if (takeBranch) begin
      pcSel = pcBranch;
    end else begin
      pcSel = pcInc;
    end
  end

  // Control part of the execute/memory register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      emWrite <= 1'b0;
      emStore <= 1'b0;
      emIsHalt <= 1'b0;
    end else if (advance) begin
      emWrite <= deWrite;
      emStore <= deStore;
      emIsHalt <= deIsHalt;
    end
  end

  // Payload where the result doubles as store address
  always_ff @(posedge CLK) begin
    if (advance) begin
      emResult <= result;
      emStoreData <= opB;
      emDest <= deDest;
    end
  end

endmodule

// ==== src/hazardUnit.sv ====
// Forwarding select and redirect squash logic, combinational, steering the pipeline stages
`timescale 1ns/10ps

module hazardUnit (
  input  mipsPkg::regIdxT deRs,
  input  mipsPkg::regIdxT deRt,
  input  mipsPkg::regIdxT emDest,
  input  logic            emWrite,
  input  mipsPkg::regIdxT mwDest,
  input  logic            mwWrite,
  input  logic            takeRedirect,
  output mipsPkg::fwdSelT fwdA,
  output mipsPkg::fwdSelT fwdB,
  output logic            squash
);
  import mipsPkg::*;

  // Youngest producer first, register 0 always from the file
  function automatic fwdSelT pickSource(input regIdxT src, input regIdxT memDest,
                                        input logic memWrite, input regIdxT wbDest,
                                        input logic wbWrite);
    fwdSelT sel;
    if (src == regZero) begin
      sel = fwdReg;
    end else if (memWrite && memDest == src) begin
      sel = fwdMem;
    end else if (wbWrite && wbDest == src) begin
      sel = fwdWb;
    end else begin
      sel = fwdReg;
    end
    return sel;
  endfunction

  assign fwdA = pickSource(deRs, emDest, emWrite, mwDest, mwWrite);
  assign fwdB = pickSource(deRt, emDest, emWrite, mwDest, mwWrite);

  // Kill the two younger instructions behind a taken branch or jump
  assign squash = takeRedirect;

endmodule

// ==== src/registerFile.sv ====
// Thirty-two word register file with write-through reads, read in decode and written from writeback
`timescale 1ns/10ps

module registerFile (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            wen,
  input  mipsPkg::regIdxT wsel,
  input  mipsPkg::wordT   wdat,
  input  mipsPkg::regIdxT rselA,
  input  mipsPkg::regIdxT rselB,
  output mipsPkg::wordT   rdatA,
  output mipsPkg::wordT   rdatB
);
  import mipsPkg::*;

  wordT regs [32];

  // Register 0 is never written
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && wsel != regZero) begin
      regs[wsel] <= wdat;
    end
  end

  // Same-cycle write shows through to the read
  function automatic wordT readPort(input regIdxT sel, input logic we, input regIdxT ws,
                                    input wordT wd, input wordT stored);
    wordT val;
    if (sel == regZero) begin
      val = '0;
    end else if (we && ws == sel) begin
      val = wd;
    end else begin
      val = stored;
    end
    return val;
  endfunction

  assign rdatA = readPort(rselA, wen, wsel, wdat, regs[rselA]);
  assign rdatB = readPort(rselB, wen, wsel, wdat, regs[rselB]);

endmodule

// ==== src/decodeStage.sv ====
// Decode stage with control decode, immediate extender and decode/execute register, used by the top
`timescale 1ns/10ps

module decodeStage (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           advance,
  input  logic           squash,
  input  mipsPkg::wordT  fdInstr,
  input  mipsPkg::wordT  fdPcInc,
  input  mipsPkg::wordT  rdatA,
  input  mipsPkg::wordT  rdatB,
  output mipsPkg::regIdxT rselA,
  output mipsPkg::regIdxT rselB,
  output mipsPkg::wordT  deBusA,
  output mipsPkg::wordT  deBusB,
  output mipsPkg::wordT  deImm,
  output mipsPkg::wordT  dePcInc,
  output mipsPkg::regIdxT deRs,
  output mipsPkg::regIdxT deRt,
  output mipsPkg::regIdxT deDest,
  output mipsPkg::aluOpT deAluOp,
  output logic           deUseImm,
  output logic           deWrite,
  output logic           deStore,
  output logic           deIsLui,
  output logic           deIsBeq,
  output logic           deIsBne,
  output logic           deIsJump,
  output logic           deIsHalt,
  output logic [25:0]    deJumpField
);
  import mipsPkg::*;

  opcodeT opcode;
  functT  funct;
  aluOpT  aluOp;
  wordT   imm;
  regIdxT dest;
  logic   useImm, write, store, destIsRt;
  logic   isLui, isBeq, isBne, isJump, isHalt;

  assign opcode = fdInstr[31:26];
  assign funct  = fdInstr[5:0];
  assign rselA  = fdInstr[25:21];
  assign rselB  = fdInstr[20:16];

  ////////////////////
  // Control decode
  ////////////////////

  always_comb begin
    aluOp = aluAdd;
    useImm = 1'b0;
    write = 1'b0;
    store = 1'b0;
    destIsRt = 1'b0;
    isLui = 1'b0;
    isBeq = 1'b0;
    isBne = 1'b0;
    isJump = 1'b0;
    isHalt = 1'b0;
    case (opcode)
      opRtype: begin
        // Unknown funct stays a no-op
        write = 1'b1;
        case (funct)
          fnAddu:  aluOp = aluAdd;
          fnSubu:  aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnSlt:   aluOp = aluSlt;
          default: write = 1'b0;
        endcase
      end
      opAddiu: begin
        useImm = 1'b1;
        write = 1'b1;
        destIsRt = 1'b1;
      end
      opOri: begin
        aluOp = aluOr;
        useImm = 1'b1;
        write = 1'b1;
        destIsRt = 1'b1;
      end
      opLui: begin
        isLui = 1'b1;
        write = 1'b1;
        destIsRt = 1'b1;
      end
      // Branches compare by subtraction
      opBeq: begin
        aluOp = aluSub;
        isBeq = 1'b1;
      end
      opBne: begin
        aluOp = aluSub;
        isBne = 1'b1;
      end
      opJ:    isJump = 1'b1;
      // Store address is rs plus offset
      opSw: begin
        useImm = 1'b1;
        store = 1'b1;
      end
      opHalt: isHalt = 1'b1;
      default: ;
    endcase
  end

  // ORI zero-extends, everything else sign-extends
  assign imm  = (opcode == opOri) ? {16'h0000, fdInstr[15:0]} : {{16{fdInstr[15]}}, fdInstr[15:0]};
  assign dest = destIsRt ? fdInstr[20:16] : fdInstr[15:11];

  ////////////////////
  // Decode/execute register
  ////////////////////

  // Control bits clear to a bubble on reset or squash
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {deWrite, deStore, deIsLui, deIsBeq, deIsBne, deIsJump, deIsHalt} <= '0;
    end else if (advance) begin
      if (squash) begin
        {deWrite, deStore, deIsLui, deIsBeq, deIsBne, deIsJump, deIsHalt} <= '0;
      end else begin
        {deWrite, deStore, deIsLui, deIsBeq, deIsBne, deIsJump, deIsHalt} <=
          {write, store, isLui, isBeq, isBne, isJump, isHalt};
      end
    end
  end

  // Operands and fields
  always_ff @(posedge CLK) begin
    if (advance) begin
      deBusA <= rdatA;
      deBusB <= rdatB;
      deImm <= imm;
      dePcInc <= fdPcInc;
      deRs <= rselA;
      deRt <= rselB;
      deDest <= dest;
      deAluOp <= aluOp;
      deUseImm <= useImm;
      deJumpField <= fdInstr[25:0];
    end
  end

endmodule

// ==== src/fetchStage.sv ====
// Fetch stage with the PC, next-PC mux and fetch/decode register, instantiated by pipelineCpu
`timescale 1ns/10ps

module fetchStage #(
  parameter mipsPkg::wordT pcInit = '0
) (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          advance,
  input  mipsPkg::pcSelT pcSel,
  input  mipsPkg::wordT branchTarget,
  input  mipsPkg::wordT jumpTarget,
  input  logic          squash,
  input  mipsPkg::wordT imemload,
  output mipsPkg::wordT pc,
  output mipsPkg::wordT fdInstr,
  output mipsPkg::wordT fdPcInc
);
  import mipsPkg::*;

  wordT pcPlus4;
  wordT pcNext;

  assign pcPlus4 = pc + 32'd4;

  // Redirect from execute wins over sequential fetch
  always_comb begin
    case (pcSel)
      pcBranch: pcNext = branchTarget;
      pcJump:   pcNext = jumpTarget;
      default:  pcNext = pcPlus4;
    endcase
  end

  // Program counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= pcInit;
    end else if (advance) begin
      pc <= pcNext;
    end
  end

  ////////////////////
  // Fetch/decode register
  ////////////////////

  // Zero word decodes as a no-op, so a squash just loads zero
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fdInstr <= '0;
    end else if (advance) begin
      fdInstr <= squash ? '0 : imemload;
    end
  end

  // PC+4 travels along for branch and jump targets
  always_ff @(posedge CLK) begin
    if (advance) begin
      fdPcInc <= pcPlus4;
    end
  end

endmodule

// ==== src/mipsPkg.sv ====
// Shared word types and instruction encodings, imported by every stage of the pipelined core
package mipsPkg;

  // Data, address and instruction word
  typedef logic [31:0] wordT;
  // Register number
  typedef logic [4:0] regIdxT;

  // Instruction fields
  typedef logic [5:0] opcodeT;
  typedef logic [5:0] functT;

  // Internal select codes
  typedef logic [2:0] aluOpT;
  typedef logic [1:0] fwdSelT;
  typedef logic [1:0] pcSelT;

  // Opcodes of the kept subset
  localparam opcodeT opRtype = 6'b000000;
  localparam opcodeT opJ     = 6'b000010;
  localparam opcodeT opBeq   = 6'b000100;
  localparam opcodeT opBne   = 6'b000101;
  localparam opcodeT opAddiu = 6'b001001;
  localparam opcodeT opOri   = 6'b001101;
  localparam opcodeT opLui   = 6'b001111;
  localparam opcodeT opSw    = 6'b101011;
  localparam opcodeT opHalt  = 6'b111111;

  // R-type funct codes
  localparam functT fnAddu = 6'b100001;
  localparam functT fnSubu = 6'b100011;
  localparam functT fnAnd  = 6'b100100;
  localparam functT fnOr   = 6'b100101;
  localparam functT fnSlt  = 6'b101010;

  // ALU operations
  localparam aluOpT aluAdd = 3'd0;
  localparam aluOpT aluSub = 3'd1;
  localparam aluOpT aluAnd = 3'd2;
  localparam aluOpT aluOr  = 3'd3;
  localparam aluOpT aluSlt = 3'd4;

  // Operand sources for execute
  localparam fwdSelT fwdReg = 2'd0;
  localparam fwdSelT fwdMem = 2'd1;
  localparam fwdSelT fwdWb  = 2'd2;

  // Next-PC sources
  localparam pcSelT pcInc    = 2'd0;
  localparam pcSelT pcBranch = 2'd1;
  localparam pcSelT pcJump   = 2'd2;

  localparam regIdxT regZero = 5'd0;

endpackage
